/* logic/capture_pkg.sv */
/*
  shared sizes and encodings for the sample capture core
  all widths are fixed here, the modules carry no parameters
  single clock domain, clk_245_76MHz
*/

package capture_pkg;

  ////////////////////
  // data widths
  ////////////////////

  // one I or Q sample
  localparam int SAMPLE_W = 16;
  // packed I over Q
  localparam int LANE_W = 32;
  // upper lane over lower lane
  localparam int WORD_W = 64;
  localparam int CTRL_W = 32;

  ////////////////////
  // timing and sizes
  ////////////////////

  // capture hold-off after init or enable fall
  localparam int DDS_LATENCY = 2;
  localparam int LAT_W = 4;

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW = 4;

  // credits after reset, equals consumer buffer depth
  localparam int CREDIT_MAX = 4;
  // must hold CREDIT_MAX plus one stray return
  localparam int CREDIT_W = 3;

  ////////////////////
  // encodings
  ////////////////////

  // lane route select, control word bits 1:0 and 5:4
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ   = 2'd0,
    ROUTE_DAC_IQ   = 2'd1,
    ROUTE_ADC_CNT  = 2'd2,
    ROUTE_GLBL_CNT = 2'd3
  } route_e;

  // chirp source, waveform player only when bits 9:8 are both set
  typedef enum logic {
    SRC_DDS  = 1'b0,
    SRC_WFRM = 1'b1
  } source_e;

  typedef enum logic [1:0] {
    FRAME_IDLE = 2'd0,
    FRAME_HOLD = 2'd1,
    FRAME_RUN  = 2'd2
  } frame_e;

endpackage

/* logic/capture_ctrl.sv */
/*
  capture enable with DDS latency hold-off
  adc_enable_i is taken as synchronous to clk_245_76MHz
  frame_head_o lags its condition by one cycle, frame_tail_o does not
*/

`timescale 1ns/1ns

module capture_ctrl import capture_pkg::*; (
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  logic adc_enable_i,
  input  logic chirp_init_i,
  output logic capture_run_o,
  output logic frame_head_o,
  output logic frame_tail_o
);

  logic             en_r;
  logic             en_rr;
  logic [LAT_W-1:0] lat_cnt;
  logic             head_r;
  logic             head_cond;
  logic             tail_cond;
  logic             enable_fall;
  frame_e           frame_state;

  ////////////////////
  // frame state
  ////////////////////

  // hold while the DDS settles, otherwise en_rr tells run from idle
  always_comb begin
    if (lat_cnt != '0) begin
      frame_state = FRAME_HOLD;
    end else if (en_rr) begin
      frame_state = FRAME_RUN;
    end else begin
      frame_state = FRAME_IDLE;
    end
  end

  assign enable_fall = en_r & ~adc_enable_i;

  // idle with enable seen, capture opens next cycle
  assign head_cond = (frame_state == FRAME_IDLE) & en_r;
  // running with enable gone, last slot of the frame
  assign tail_cond = (frame_state == FRAME_RUN) & ~en_r;

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_r    <= 1'b0;
      en_rr   <= 1'b0;
      lat_cnt <= '0;
      head_r  <= 1'b0;
    end else begin
      en_r <= adc_enable_i;
      // en_rr frozen during hold-off
      if (frame_state != FRAME_HOLD) begin
        en_rr <= en_r;
      end
      // init wins over the enable fall, same load value anyway
      if (chirp_init_i || enable_fall) begin
        lat_cnt <= LAT_W'(DDS_LATENCY);
      end else if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - 1'b1;
      end
      head_r <= head_cond;
    end
  end

  assign capture_run_o = en_rr;
  assign frame_head_o  = head_r;
  assign frame_tail_o  = tail_cond;

  // head is a cycle late, so a tail right after it would mean a one-slot frame
  a_head_tail_excl: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(frame_head_o && frame_tail_o)
  );

endmodule

/* logic/sample_counters.sv */
/*
  sample counter and free-running global counter
  both wrap silently at 2^32
*/

`timescale 1ns/1ns

module sample_counters import capture_pkg::*; (
  input  logic              clk_245_76MHz,
  input  logic              cpu_reset,
  input  logic              wr_en_i,
  output logic [LANE_W-1:0] adc_count_o,
  output logic [LANE_W-1:0] glbl_count_o
);

  logic [LANE_W-1:0] adc_cnt;
  logic [LANE_W-1:0] glbl_cnt;

  // one step per written slot, head and tail included
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      adc_cnt <= '0;
    end else if (wr_en_i) begin
      adc_cnt <= adc_cnt + 1'b1;
    end
  end

  // cycle count since reset
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_cnt <= '0;
    end else begin
      glbl_cnt <= glbl_cnt + 1'b1;
    end
  end

  assign adc_count_o  = adc_cnt;
  assign glbl_count_o = glbl_cnt;

endmodule

/* logic/word_router.sv */
/*
  lane routing and frame word insertion
  route selects take effect one cycle after the control word
  the FIFO write itself is combinational
*/

`timescale 1ns/1ns

module word_router import capture_pkg::*; (
  input  logic                clk_245_76MHz,
  input  logic                cpu_reset,
  input  logic [CTRL_W-1:0]   chirp_control_word_i,
  input  logic                capture_run_i,
  input  logic                frame_head_i,
  input  logic                frame_tail_i,
  input  logic                adc_valid_i,
  input  logic [SAMPLE_W-1:0] adc_i_i,
  input  logic [SAMPLE_W-1:0] adc_q_i,
  input  logic [SAMPLE_W-1:0] dac_i_i,
  input  logic [SAMPLE_W-1:0] dac_q_i,
  input  logic [LANE_W-1:0]   adc_count_i,
  input  logic [LANE_W-1:0]   glbl_count_i,
  output logic                wr_en_o,
  output logic [WORD_W-1:0]   wr_data_o
);

  route_e            route_l_r;
  route_e            route_u_r;
  logic [LANE_W-1:0] adc_iq;
  logic [LANE_W-1:0] dac_iq;
  logic [LANE_W-1:0] lane_l;
  logic [LANE_W-1:0] lane_u;

  // I in the high half
  assign adc_iq = {adc_i_i, adc_q_i};
  assign dac_iq = {dac_i_i, dac_q_i};

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_l_r <= ROUTE_ADC_IQ;
      route_u_r <= ROUTE_ADC_IQ;
    end else begin
      route_l_r <= route_e'(chirp_control_word_i[1:0]);
      route_u_r <= route_e'(chirp_control_word_i[5:4]);
    end
  end

  ////////////////////
  // lane muxes
  ////////////////////

  always_comb begin
    case (route_l_r)
      ROUTE_ADC_IQ:  lane_l = adc_iq;
      ROUTE_DAC_IQ:  lane_l = dac_iq;
      ROUTE_ADC_CNT: lane_l = adc_count_i;
      default:       lane_l = glbl_count_i;
    endcase
  end

  always_comb begin
    case (route_u_r)
      ROUTE_ADC_IQ:  lane_u = adc_iq;
      ROUTE_DAC_IQ:  lane_u = dac_iq;
      ROUTE_ADC_CNT: lane_u = adc_count_i;
      default:       lane_u = glbl_count_i;
    endcase
  end

  assign wr_en_o = capture_run_i & adc_valid_i;

  // head and tail slots carry the counters in place of samples
  assign wr_data_o = (frame_head_i | frame_tail_i) ? {glbl_count_i, adc_count_i}
                                                   : {lane_u, lane_l};

endmodule

/* logic/chirp_source_mux.sv */
/*
  chirp control steering between DDS and waveform player
  source select registered from control word bits 9:8
  the unselected source sees init and enable held low
*/

`timescale 1ns/1ns

module chirp_source_mux import capture_pkg::*; (
  input  logic              clk_245_76MHz,
  input  logic              cpu_reset,
  input  logic [CTRL_W-1:0] chirp_control_word_i,
  input  logic              chirp_init_i,
  input  logic              chirp_enable_i,
  input  logic              dds_ready_i,
  input  logic              dds_done_i,
  input  logic              dds_active_i,
  input  logic              wfrm_ready_i,
  input  logic              wfrm_done_i,
  input  logic              wfrm_active_i,
  output logic              dds_init_o,
  output logic              dds_enable_o,
  output logic              wfrm_init_o,
  output logic              wfrm_enable_o,
  output logic              chirp_ready_o,
  output logic              chirp_done_o,
  output logic              chirp_active_o
);

  source_e src_r;
  logic    wfrm_sel;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      src_r <= SRC_DDS;
    end else begin
      src_r <= (&chirp_control_word_i[9:8]) ? SRC_WFRM : SRC_DDS;
    end
  end

  assign wfrm_sel = (src_r == SRC_WFRM);

  // control out
  assign dds_init_o    = ~wfrm_sel & chirp_init_i;
  assign dds_enable_o  = ~wfrm_sel & chirp_enable_i;
  assign wfrm_init_o   =  wfrm_sel & chirp_init_i;
  assign wfrm_enable_o =  wfrm_sel & chirp_enable_i;

  // status back from the chosen source
  assign chirp_ready_o  = wfrm_sel ? wfrm_ready_i  : dds_ready_i;
  assign chirp_done_o   = wfrm_sel ? wfrm_done_i   : dds_done_i;
  assign chirp_active_o = wfrm_sel ? wfrm_active_i : dds_active_i;

  a_init_onehot: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(dds_init_o && wfrm_init_o)
  );

endmodule

/* logic/capture_fifo.sv */
/*
  capture FIFO, 16 words, drained over credit flow control
  one word per out_valid_o pulse, one credit spent per word
  writes into a full FIFO are lost and set overflow_o until reset
*/

`timescale 1ns/1ns

module capture_fifo import capture_pkg::*; (
  input  logic              clk_245_76MHz,
  input  logic              cpu_reset,
  input  logic              wr_en_i,
  input  logic [WORD_W-1:0] wr_data_i,
  input  logic              credit_return_i,
  output logic              out_valid_o,
  output logic [WORD_W-1:0] out_data_o,
  output logic              overflow_o
);

  logic [WORD_W-1:0]   mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]  wr_ptr;
  logic [FIFO_AW-1:0]  rd_ptr;
  logic [FIFO_AW:0]    fill;
  logic [CREDIT_W-1:0] credits;
  logic                full;
  logic                empty;
  logic                do_wr;
  logic                do_rd;
  logic                out_valid_r;
  logic                overflow_r;

  assign full  = (fill == (FIFO_AW+1)'(FIFO_DEPTH));
  assign empty = (fill == '0);
  assign do_wr = wr_en_i & ~full;
  // pop only with a credit in hand
  assign do_rd = ~empty & (credits != '0);

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
    // data lands with out_valid_o one cycle after the pop
    if (do_rd) begin
      out_data_o <= mem[rd_ptr];
    end
  end

  ////////////////////
  // pointers, credits
  ////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fill        <= '0;
      credits     <= CREDIT_W'(CREDIT_MAX);
      out_valid_r <= 1'b0;
      overflow_r  <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill        <= fill + do_wr - do_rd;
      // spend on pop, earn on each returned pulse
      credits     <= credits - do_rd + credit_return_i;
      out_valid_r <= do_rd;
      // sticky
      if (wr_en_i && full) begin
        overflow_r <= 1'b1;
      end
    end
  end

  assign out_valid_o = out_valid_r;
  assign overflow_o  = overflow_r;

  // consumer must not hand back more than it was given
  a_credit_max: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    credits <= CREDIT_W'(CREDIT_MAX)
  );

  a_no_send_without_credit: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    out_valid_o |-> $past(credits) != '0
  );

endmodule

/* logic/adc_capture_top.sv */
/*
  radar sample capture framing core
  DDS and waveform player sit outside, only their status enters here
  output side is credit based, CREDIT_MAX credits after reset
*/

`timescale 1ns/1ns

module adc_capture_top import capture_pkg::*; (
  input  logic                clk_245_76MHz,
  input  logic                cpu_reset,
  input  logic [CTRL_W-1:0]   chirp_control_word_i,
  input  logic                chirp_init_i,
  input  logic                chirp_enable_i,
  input  logic                adc_enable_i,
  input  logic [SAMPLE_W-1:0] adc_i_i,
  input  logic [SAMPLE_W-1:0] adc_q_i,
  input  logic [SAMPLE_W-1:0] dac_i_i,
  input  logic [SAMPLE_W-1:0] dac_q_i,
  input  logic                adc_valid_i,
  input  logic                dds_ready_i,
  input  logic                dds_done_i,
  input  logic                dds_active_i,
  input  logic                wfrm_ready_i,
  input  logic                wfrm_done_i,
  input  logic                wfrm_active_i,
  input  logic                credit_return_i,
  output logic                dds_init_o,
  output logic                dds_enable_o,
  output logic                wfrm_init_o,
  output logic                wfrm_enable_o,
  output logic                chirp_ready_o,
  output logic                chirp_done_o,
  output logic                chirp_active_o,
  output logic                out_valid_o,
  output logic [WORD_W-1:0]   out_data_o,
  output logic                overflow_o
);

  logic              capture_run;
  logic              frame_head;
  logic              frame_tail;
  logic              wr_en;
  logic [WORD_W-1:0] wr_data;
  logic [LANE_W-1:0] adc_count;
  logic [LANE_W-1:0] glbl_count;

  ////////////////////
  // capture path
  ////////////////////

  capture_ctrl u_capture_ctrl (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable_i  (adc_enable_i),
    .chirp_init_i  (chirp_init_i),
    .capture_run_o (capture_run),
    .frame_head_o  (frame_head),
    .frame_tail_o  (frame_tail)
  );

  // counts the same write strobe that feeds the FIFO
  sample_counters u_sample_counters (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .wr_en_i       (wr_en),
    .adc_count_o   (adc_count),
    .glbl_count_o  (glbl_count)
  );

  word_router u_word_router (
    .clk_245_76MHz        (clk_245_76MHz),
    .cpu_reset            (cpu_reset),
    .chirp_control_word_i (chirp_control_word_i),
    .capture_run_i        (capture_run),
    .frame_head_i         (frame_head),
    .frame_tail_i         (frame_tail),
    .adc_valid_i          (adc_valid_i),
    .adc_i_i              (adc_i_i),
    .adc_q_i              (adc_q_i),
    .dac_i_i              (dac_i_i),
    .dac_q_i              (dac_q_i),
    .adc_count_i          (adc_count),
    .glbl_count_i         (glbl_count),
    .wr_en_o              (wr_en),
    .wr_data_o            (wr_data)
  );

  capture_fifo u_capture_fifo (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .wr_en_i         (wr_en),
    .wr_data_i       (wr_data),
    .credit_return_i (credit_return_i),
    .out_valid_o     (out_valid_o),
    .out_data_o      (out_data_o),
    .overflow_o      (overflow_o)
  );

  ////////////////////
  // chirp control
  ////////////////////

  chirp_source_mux u_chirp_source_mux (
    .clk_245_76MHz        (clk_245_76MHz),
    .cpu_reset            (cpu_reset),
    .chirp_control_word_i (chirp_control_word_i),
    .chirp_init_i         (chirp_init_i),
    .chirp_enable_i       (chirp_enable_i),
    .dds_ready_i          (dds_ready_i),
    .dds_done_i           (dds_done_i),
    .dds_active_i         (dds_active_i),
    .wfrm_ready_i         (wfrm_ready_i),
    .wfrm_done_i          (wfrm_done_i),
    .wfrm_active_i        (wfrm_active_i),
    .dds_init_o           (dds_init_o),
    .dds_enable_o         (dds_enable_o),
    .wfrm_init_o          (wfrm_init_o),
    .wfrm_enable_o        (wfrm_enable_o),
    .chirp_ready_o        (chirp_ready_o),
    .chirp_done_o         (chirp_done_o),
    .chirp_active_o       (chirp_active_o)
  );

endmodule

/* testbench/tb_adc_capture_table.svh */
/*
  frame table for the capture testbench, one row per frame
  each row holds name, control word, enable cycles, seed mix and credit mode
  data words per frame are enable cycles plus DDS_LATENCY minus 2
  the overflow row stays last since it leaves the FIFO dirty
*/

`ifndef TB_ADC_CAPTURE_TABLE_SVH
`define TB_ADC_CAPTURE_TABLE_SVH

// credit modes of the consumer model
localparam int CR_PROMPT = 0;
// withhold until the frame is written
localparam int CR_HOLD = 1;
// never return, used to force overflow
localparam int CR_NONE = 2;

localparam int ROWS = 8;

string       row_name   [ROWS];
logic [31:0] row_ctrl   [ROWS];
int          row_len    [ROWS];
logic [31:0] row_seed   [ROWS];
int          row_credit [ROWS];

task automatic set_row(input int idx, input string name, input logic [31:0] ctrl,
                       input int len, input logic [31:0] seed_mix, input int credit);
  row_name[idx]   = name;
  row_ctrl[idx]   = ctrl;
  row_len[idx]    = len;
  row_seed[idx]   = seed_mix;
  row_credit[idx] = credit;
endtask

// ctrl bits 1:0 lower route, 5:4 upper route, 9:8 source
task automatic fill_table;
  set_row(0, "adc_iq",        32'h0000_0000,  6, 32'h0000_0000, CR_PROMPT);
  set_row(1, "dac_iq",        32'h0000_0011,  8, 32'h0000_0101, CR_PROMPT);
  // waveform player, upper lane DAC
  set_row(2, "mixed_wfrm",    32'h0000_0310,  5, 32'h0000_0202, CR_PROMPT);
  // upper lane global count, masked
  set_row(3, "adc_cnt_lower", 32'h0000_0032,  7, 32'h0000_0303, CR_PROMPT);
  // only bit 9 set, still DDS
  set_row(4, "src_bit9_only", 32'h0000_0200,  3, 32'h0000_0404, CR_PROMPT);
  set_row(5, "credit_hold",   32'h0000_0001, 10, 32'h0000_0505, CR_HOLD);
  set_row(6, "wfrm_cnt",      32'h0000_0302,  4, 32'h0000_0606, CR_PROMPT);
  set_row(7, "overflow",      32'h0000_0000, 20, 32'h0000_0707, CR_NONE);
endtask

`endif

/* testbench/tb_adc_capture.sv */
/*
  testbench for the capture framing core
  consumer model returns credits per table row
  global count halves are masked, never compared
*/

`timescale 1ns/1ns

module tb_adc_capture import capture_pkg::*;;

  localparam logic [31:0] SEED_BASE = 32'h4824_e533;
  localparam logic [63:0] HALF_MASK = 64'h0000_0000_ffff_ffff;

  logic                clk_245_76MHz;
  logic                cpu_reset;
  logic [CTRL_W-1:0]   chirp_control_word_i;
  logic                chirp_init_i;
  logic                chirp_enable_i;
  logic                adc_enable_i;
  logic [SAMPLE_W-1:0] adc_i_i;
  logic [SAMPLE_W-1:0] adc_q_i;
  logic [SAMPLE_W-1:0] dac_i_i;
  logic [SAMPLE_W-1:0] dac_q_i;
  logic                adc_valid_i;
  logic                dds_ready_i;
  logic                dds_done_i;
  logic                dds_active_i;
  logic                wfrm_ready_i;
  logic                wfrm_done_i;
  logic                wfrm_active_i;
  // driven by the consumer model only
  logic                credit_return_i = 1'b0;
  logic                dds_init_o;
  logic                dds_enable_o;
  logic                wfrm_init_o;
  logic                wfrm_enable_o;
  logic                chirp_ready_o;
  logic                chirp_done_o;
  logic                chirp_active_o;
  logic                out_valid_o;
  logic [WORD_W-1:0]   out_data_o;
  logic                overflow_o;

  logic [63:0] exp_q [$];
  logic [63:0] mask_q [$];
  logic [63:0] exp_word;
  logic [63:0] exp_mask;
  string       cur_test;
  integer      seed;
  int          err_cnt;
  int          check_cnt;
  int          rx_cnt;
  int          owed;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] model_cnt;
  logic        credit_release;
  logic        ignore_out;

  `include "tb_adc_capture_table.svh"

  adc_capture_top DUT (.*);

  always #50 clk_245_76MHz = ~clk_245_76MHz;

  ////////////////////
  // helpers
  ////////////////////

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    check_cnt = check_cnt + 1;
    if (act !== exp) begin
      err_cnt = err_cnt + 1;
      $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // lane contents by route, count is the sample count at the write
  function automatic logic [31:0] lane_expect(input logic [1:0] route,
                                              input logic [31:0] adc_iq,
                                              input logic [31:0] dac_iq,
                                              input logic [31:0] cnt);
    if (route == ROUTE_ADC_IQ) begin
      return adc_iq;
    end else if (route == ROUTE_DAC_IQ) begin
      return dac_iq;
    end else if (route == ROUTE_ADC_CNT) begin
      return cnt;
    end
    return 32'h0;
  endfunction

  // global count lanes not predicted
  function automatic logic [31:0] lane_mask(input logic [1:0] route);
    return (route == ROUTE_GLBL_CNT) ? 32'h0 : 32'hffff_ffff;
  endfunction

  // pulse init and enable, status inputs complementary per source
  task automatic steer_chirp(input logic [31:0] ctrl);
    logic [31:0] r;
    logic        wfrm;
    logic        exp_ready;
    logic        exp_done;
    logic        exp_active;
    wfrm       = &ctrl[9:8];
    r          = $random(seed);
    exp_ready  = wfrm ? ~r[0] : r[0];
    exp_done   = wfrm ? ~r[1] : r[1];
    exp_active = wfrm ? ~r[2] : r[2];
    @(posedge clk_245_76MHz);
    chirp_init_i   <= 1'b1;
    chirp_enable_i <= 1'b1;
    dds_ready_i    <= r[0];
    dds_done_i     <= r[1];
    dds_active_i   <= r[2];
    wfrm_ready_i   <= ~r[0];
    wfrm_done_i    <= ~r[1];
    wfrm_active_i  <= ~r[2];
    @(negedge clk_245_76MHz);
    check("dds_init", !wfrm, dds_init_o);
    check("dds_enable", !wfrm, dds_enable_o);
    check("wfrm_init", wfrm, wfrm_init_o);
    check("wfrm_enable", wfrm, wfrm_enable_o);
    check("chirp_ready", exp_ready, chirp_ready_o);
    check("chirp_done", exp_done, chirp_done_o);
    check("chirp_active", exp_active, chirp_active_o);
    @(posedge clk_245_76MHz);
    chirp_init_i   <= 1'b0;
    chirp_enable_i <= 1'b0;
    // let the DDS hold-off run out before the frame
    repeat (3) @(posedge clk_245_76MHz);
  endtask

  ////////////////////
  // frame stimulus
  ////////////////////

  // enable high for len cycles, valid kept up until the tail is written
  task automatic run_frame(input int idx);
    int          n;
    int          last_data;
    logic [31:0] ctrl;
    logic [31:0] r_adc;
    logic [31:0] r_dac;
    logic [31:0] cnt;
    logic [31:0] lo;
    logic [31:0] hi;
    ctrl      = row_ctrl[idx];
    last_data = row_len[idx] + DDS_LATENCY;
    cnt       = model_cnt;
    // head slot is the first write
    exp_q.push_back({32'h0, cnt});
    mask_q.push_back(HALF_MASK);
    cnt = cnt + 1;
    for (n = 0; n <= last_data + 3; n = n + 1) begin
      @(posedge clk_245_76MHz);
      r_adc = $random(seed);
      r_dac = $random(seed);
      adc_i_i      <= r_adc[31:16];
      adc_q_i      <= r_adc[15:0];
      dac_i_i      <= r_dac[31:16];
      dac_q_i      <= r_dac[15:0];
      adc_enable_i <= (n < row_len[idx]);
      adc_valid_i  <= (n < last_data + 3);
      // samples driven here are written on the next edge
      if (n >= 3 && n <= last_data) begin
        lo = lane_expect(ctrl[1:0], r_adc, r_dac, cnt);
        hi = lane_expect(ctrl[5:4], r_adc, r_dac, cnt);
        exp_q.push_back({hi, lo});
        mask_q.push_back({lane_mask(ctrl[5:4]), lane_mask(ctrl[1:0])});
        cnt = cnt + 1;
      end
      // tail follows the last data slot
      if (n == last_data) begin
        exp_q.push_back({32'h0, cnt});
        mask_q.push_back(HALF_MASK);
        cnt = cnt + 1;
      end
    end
    model_cnt = cnt;
  endtask

  ////////////////////
  // consumer model
  ////////////////////

  always @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      credit_return_i <= 1'b0;
    end else begin
      if (out_valid_o) begin
        rx_cnt = rx_cnt + 1;
        owed   = owed + 1;
        if (!ignore_out) begin
          if (exp_q.size() == 0) begin
            err_cnt = err_cnt + 1;
            $display("unexpected output word %h in test %s", out_data_o, cur_test);
          end else begin
            exp_word = exp_q.pop_front();
            exp_mask = mask_q.pop_front();
            check("output word", exp_word & exp_mask, out_data_o & exp_mask);
          end
        end
      end
      // one credit per freed word, never more than received
      if (credit_release && owed > 0) begin
        credit_return_i <= 1'b1;
        owed = owed - 1;
      end else begin
        credit_return_i <= 1'b0;
      end
    end
  end

  ////////////////////
  // watchdog
  ////////////////////

  initial begin : watchdog
    cycle_cnt = 0;
    @(posedge clk_245_76MHz);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_245_76MHz);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout after %0d cycles with %0d output words still missing",
             cycle_cnt, exp_q.size());
    $display("checks %0d errors %0d words received %0d", check_cnt, err_cnt, rx_cnt);
    $display("sim failed");
    $finish;
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main_flow
    int i;
    int rx_start;
    fill_table();
    // four cycles per enable cycle plus fixed slack
    cycle_limit = 200;
    for (i = 0; i < ROWS; i = i + 1) begin
      cycle_limit = cycle_limit + 4 * row_len[i];
    end
    clk_245_76MHz        = 1'b0;
    cpu_reset            = 1'b1;
    chirp_control_word_i = '0;
    chirp_init_i         = 1'b0;
    chirp_enable_i       = 1'b0;
    adc_enable_i         = 1'b0;
    adc_i_i              = '0;
    adc_q_i              = '0;
    dac_i_i              = '0;
    dac_q_i              = '0;
    adc_valid_i          = 1'b0;
    dds_ready_i          = 1'b0;
    dds_done_i           = 1'b0;
    dds_active_i         = 1'b0;
    wfrm_ready_i         = 1'b0;
    wfrm_done_i          = 1'b0;
    wfrm_active_i        = 1'b0;
    err_cnt              = 0;
    check_cnt            = 0;
    rx_cnt               = 0;
    owed                 = 0;
    model_cnt            = '0;
    credit_release       = 1'b1;
    ignore_out           = 1'b0;
    seed                 = SEED_BASE;
    repeat (8) @(posedge clk_245_76MHz);
    cpu_reset <= 1'b0;
    @(negedge clk_245_76MHz);
    // idle outputs before any enable
    cur_test = "after_reset";
    check("out_valid", 1'b0, out_valid_o);
    check("overflow", 1'b0, overflow_o);
    check("dds_init", 1'b0, dds_init_o);
    check("dds_enable", 1'b0, dds_enable_o);
    check("wfrm_init", 1'b0, wfrm_init_o);
    check("wfrm_enable", 1'b0, wfrm_enable_o);
    check("chirp_ready", 1'b0, chirp_ready_o);
    check("chirp_done", 1'b0, chirp_done_o);
    check("chirp_active", 1'b0, chirp_active_o);
    for (i = 0; i < ROWS; i = i + 1) begin
      cur_test = row_name[i];
      seed     = SEED_BASE ^ row_seed[i];
      @(posedge clk_245_76MHz);
      chirp_control_word_i <= row_ctrl[i];
      // route and source selects register one cycle later
      repeat (2) @(posedge clk_245_76MHz);
      steer_chirp(row_ctrl[i]);
      @(negedge clk_245_76MHz);
      credit_release = (row_credit[i] == CR_PROMPT);
      ignore_out     = (row_credit[i] == CR_NONE);
      rx_start       = rx_cnt;
      run_frame(i);
      if (row_credit[i] == CR_NONE) begin
        @(negedge clk_245_76MHz);
        check("overflow", 1'b1, overflow_o);
      end else begin
        if (row_credit[i] == CR_HOLD) begin
          repeat (4) @(negedge clk_245_76MHz);
          check("words before credits", CREDIT_MAX, rx_cnt - rx_start);
          credit_release = 1'b1;
        end
        // drain on returned credits
        while (exp_q.size() != 0) begin
          @(negedge clk_245_76MHz);
        end
        check("overflow", 1'b0, overflow_o);
      end
    end
    $display("checks %0d errors %0d words received %0d", check_cnt, err_cnt, rx_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+testbench
logic/capture_pkg.sv
logic/capture_ctrl.sv
logic/sample_counters.sv
logic/word_router.sv
logic/chirp_source_mux.sv
logic/capture_fifo.sv
logic/adc_capture_top.sv
testbench/tb_adc_capture.sv

/* Bender.yml */
package:
  name: adc_capture

sources:
  - logic/capture_pkg.sv
  - logic/capture_ctrl.sv
  - logic/sample_counters.sv
  - logic/word_router.sv
  - logic/chirp_source_mux.sv
  - logic/capture_fifo.sv
  - logic/adc_capture_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_adc_capture.sv
